// File: rtl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and address widths
`define MIPS_XLEN       32
`define MIPS_REG_AW     5
`define MIPS_IM_AW      6
`define MIPS_DM_AW      6

`define MIPS_IM_DEPTH   (1 << `MIPS_IM_AW)
`define MIPS_DM_DEPTH   (1 << `MIPS_DM_AW)
`define MIPS_NREGS      (1 << `MIPS_REG_AW)

// Opcodes, instr[31:26]
`define OP_RTYPE        6'h00
`define OP_ADDIU        6'h09
`define OP_LW           6'h23
`define OP_SW           6'h2b
`define OP_HALT         6'h3f

// Function codes, instr[5:0]
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_SLT          6'h2a

`endif

// File: rtl/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]   word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // IF/ID
    typedef struct packed {
        word_t      instr;
        logic       halt;
    } if_id_t;

    // ID/EX
    typedef struct packed {
        alu_op_e    alu_op;
        logic       imm_sel;    // Operand b from immediate
        word_t      op_a;
        word_t      op_b;
        word_t      imm;        // Sign extended
        reg_addr_t  dest;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       halt;
    } id_ex_t;

    // EX/MEM
    typedef struct packed {
        word_t      alu_result;
        word_t      store_data;
        reg_addr_t  dest;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       halt;
    } ex_mem_t;

    // Writeback bus into the register bank
    typedef struct packed {
        logic       reg_write;
        reg_addr_t  dest;
        word_t      data;
    } wb_t;

endpackage

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clock,
    input  logic     i_arst_n,
    input  logic     i_enable,
    input  payload_t i_d,
    output payload_t o_q
);

    // All-zero payload is a bubble
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_q <= '0;
        end else if (i_enable) begin
            o_q <= i_d;
        end
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module fetch_stage
    import mips_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic                   i_pc_enable,
    input  logic                   i_im_write_enable,
    input  logic [`MIPS_IM_AW-1:0] i_im_address,
    input  word_t                  i_im_data,
    output word_t                  o_pc_value,
    output if_id_t                 o_if
);

    word_t  imem [`MIPS_IM_DEPTH];
    word_t  pc;
    word_t  instr;
    logic   is_halt;
    logic   halted;

    assign instr   = imem[pc[`MIPS_IM_AW+1:2]];   // Word index from byte PC
    assign is_halt = (instr[31:26] == `OP_HALT);

    // Debug load only while the core is stopped
    always_ff @(posedge i_clock) begin
        if (i_im_write_enable && !i_pc_enable) begin
            imem[i_im_address] <= i_im_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (i_pc_enable && !halted) begin
            pc <= pc + 4;
            if (is_halt) begin
                halted <= 1'b1;     // PC rests one word past halt
            end
        end
    end

    assign o_pc_value = pc;

    // Bubbles once halted
    always_comb begin
        o_if = '0;
        if (!halted) begin
            o_if.instr = instr;
            o_if.halt  = is_halt;
        end
    end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module reg_bank
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_arst_n,
    input  reg_addr_t i_rs,
    input  reg_addr_t i_rt,
    input  reg_addr_t i_dbg_addr,
    input  wb_t       i_wb,
    output word_t     o_rs_data,
    output word_t     o_rt_data,
    output word_t     o_dbg_data
);

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.reg_write && i_wb.dest != '0) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    // Write-through read, r0 pinned to zero even against a writeback to it
    function automatic word_t read_port(input reg_addr_t addr, input word_t stored,
                                        input wb_t wb);
        if (addr == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.dest == addr) begin
            return wb.data;
        end
        return stored;
    endfunction

    assign o_rs_data  = read_port(i_rs, regs[i_rs], i_wb);
    assign o_rt_data  = read_port(i_rt, regs[i_rt], i_wb);
    assign o_dbg_data = read_port(i_dbg_addr, regs[i_dbg_addr], i_wb);

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_arst_n,
    input  if_id_t    i_if,
    input  wb_t       i_wb,
    input  reg_addr_t i_rb_address,
    output word_t     o_rb_data,
    output id_ex_t    o_ex
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      rs_data;
    word_t      rt_data;
    word_t      imm_ext;
    logic       valid;

    assign opcode  = i_if.instr[31:26];
    assign rs      = i_if.instr[25:21];
    assign rt      = i_if.instr[20:16];
    assign rd      = i_if.instr[15:11];
    assign funct   = i_if.instr[5:0];
    assign imm_ext = {{16{i_if.instr[15]}}, i_if.instr[15:0]};

    reg_bank u_reg_bank (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_dbg_addr (i_rb_address),
        .i_wb       (i_wb),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_rb_data)
    );

    always_comb begin
        o_ex      = '0;
        o_ex.op_a = rs_data;
        o_ex.op_b = rt_data;
        o_ex.imm  = imm_ext;
        o_ex.dest = rt;         // I-type target
        valid     = 1'b1;
        case (opcode)
            `OP_RTYPE: begin
                o_ex.dest      = rd;
                o_ex.reg_write = 1'b1;
                case (funct)
                    `FN_ADDU: o_ex.alu_op = ALU_ADD;
                    `FN_SUBU: o_ex.alu_op = ALU_SUB;
                    `FN_AND:  o_ex.alu_op = ALU_AND;
                    `FN_OR:   o_ex.alu_op = ALU_OR;
                    `FN_SLT:  o_ex.alu_op = ALU_SLT;
                    default:  valid = 1'b0;     // Includes the zero nop
                endcase
            end
            `OP_ADDIU: begin
                o_ex.imm_sel   = 1'b1;
                o_ex.reg_write = 1'b1;
            end
            `OP_LW: begin
                o_ex.imm_sel   = 1'b1;
                o_ex.reg_write = 1'b1;
                o_ex.mem_read  = 1'b1;
            end
            `OP_SW: begin
                o_ex.imm_sel   = 1'b1;
                o_ex.mem_write = 1'b1;
            end
            `OP_HALT: o_ex.halt = i_if.halt;
            default:  valid = 1'b0;
        endcase
        if (!valid) begin
            o_ex = '0;
        end
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  id_ex_t  i_ex,
    output ex_mem_t o_mem
);

    word_t op_b;
    word_t result;

    assign op_b = i_ex.imm_sel ? i_ex.imm : i_ex.op_b;

    always_comb begin
        case (i_ex.alu_op)
            ALU_ADD: result = i_ex.op_a + op_b;
            ALU_SUB: result = i_ex.op_a - op_b;
            ALU_AND: result = i_ex.op_a & op_b;
            ALU_OR:  result = i_ex.op_a | op_b;
            ALU_SLT: result = word_t'($signed(i_ex.op_a) < $signed(op_b));
            default: result = '0;
        endcase
    end

    // Store data is always rt, never the immediate
    assign o_mem = '{
        alu_result: result,
        store_data: i_ex.op_b,
        dest:       i_ex.dest,
        reg_write:  i_ex.reg_write,
        mem_read:   i_ex.mem_read,
        mem_write:  i_ex.mem_write,
        halt:       i_ex.halt
    };

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module memory_stage
    import mips_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic                   i_enable,
    input  ex_mem_t                i_mem,
    input  logic [`MIPS_DM_AW-1:0] i_dm_address,
    output word_t                  o_dm_data,
    output wb_t                    o_wb,
    output logic                   o_hlt
);

    word_t                  dmem [`MIPS_DM_DEPTH];
    logic [`MIPS_DM_AW-1:0] word_idx;
    word_t                  load_data;

    // MEM/WB
    logic      wb_reg_write;
    logic      wb_mem_read;
    reg_addr_t wb_dest;
    word_t     wb_alu;
    logic      hlt_q;

    assign word_idx = i_mem.alu_result[`MIPS_DM_AW+1:2];

    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            if (i_mem.mem_write) begin
                dmem[word_idx] <= i_mem.store_data;
            end
            load_data <= dmem[word_idx];    // Lines up with MEM/WB
            wb_alu    <= i_mem.alu_result;
        end
        o_dm_data <= dmem[i_dm_address];    // Debug read
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
            wb_dest      <= '0;
            hlt_q        <= 1'b0;
        end else if (i_enable) begin
            wb_reg_write <= i_mem.reg_write;
            wb_mem_read  <= i_mem.mem_read;
            wb_dest      <= i_mem.dest;
            if (i_mem.halt) begin
                hlt_q <= 1'b1;      // Sticky until reset
            end
        end
    end

    assign o_wb.reg_write = wb_reg_write;
    assign o_wb.dest      = wb_dest;
    assign o_wb.data      = wb_mem_read ? load_data : wb_alu;
    assign o_hlt          = hlt_q;

endmodule

// File: rtl/mips_top.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_top
    import mips_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  logic                   i_pc_enable,
    input  logic                   i_im_write_enable,
    input  logic [`MIPS_IM_AW-1:0] i_im_address,
    input  word_t                  i_im_data,
    input  reg_addr_t              i_rb_address,
    input  logic [`MIPS_DM_AW-1:0] i_dm_address,
    output word_t                  o_pc_value,
    output word_t                  o_rb_data,
    output word_t                  o_dm_data,
    output logic                   o_hlt
);

    if_id_t  if_d;
    if_id_t  if_q;
    id_ex_t  id_d;
    id_ex_t  id_q;
    ex_mem_t ex_d;
    ex_mem_t ex_q;
    wb_t     wb;

    fetch_stage u_fetch (
        .i_clock           (i_clock),
        .i_arst_n          (i_arst_n),
        .i_pc_enable       (i_pc_enable),
        .i_im_write_enable (i_im_write_enable),
        .i_im_address      (i_im_address),
        .i_im_data         (i_im_data),
        .o_pc_value        (o_pc_value),
        .o_if              (if_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (i_pc_enable),
        .i_d      (if_d),
        .o_q      (if_q)
    );

    decode_stage u_decode (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_if         (if_q),
        .i_wb         (wb),
        .i_rb_address (i_rb_address),
        .o_rb_data    (o_rb_data),
        .o_ex         (id_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (i_pc_enable),
        .i_d      (id_d),
        .o_q      (id_q)
    );

    execute_stage u_execute (
        .i_ex  (id_q),
        .o_mem (ex_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (i_pc_enable),
        .i_d      (ex_d),
        .o_q      (ex_q)
    );

    // Holds MEM/WB internally
    memory_stage u_memory (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_enable     (i_pc_enable),
        .i_mem        (ex_q),
        .i_dm_address (i_dm_address),
        .o_dm_data    (o_dm_data),
        .o_wb         (wb),
        .o_hlt        (o_hlt)
    );

endmodule

// File: sim/tb_mips_top.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_mips_top
    import mips_pkg::*;
();

    localparam int PERIOD_NS  = 4;
    localparam int NUM_ROWS   = 12;
    localparam int ROW_CYCLES = 60;
    localparam int PROG_LEN   = 17;
    localparam int HALT_IDX   = 16;
    localparam int PAUSE_ROW  = 7;     // Row that gets stopped mid-run
    localparam int SWEEP_ROW  = 1;     // r1 to r4 still hold row 0 results
    localparam int WATCHDOG_NS = NUM_ROWS * ROW_CYCLES * PERIOD_NS;

    typedef struct packed {
        logic [5:0]  fn;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        word_t       expected;
    } row_t;

    logic                   clock;
    logic                   arst_n;
    logic                   pc_enable;
    logic                   im_we;
    logic [`MIPS_IM_AW-1:0] im_addr;
    word_t                  im_data;
    reg_addr_t              rb_addr;
    logic [`MIPS_DM_AW-1:0] dm_addr;
    word_t                  pc_value;
    word_t                  rb_data;
    word_t                  dm_data;
    logic                   hlt;

    row_t        rows [NUM_ROWS];
    word_t       prog [PROG_LEN];
    logic [31:0] rng_state = 32'h78e9_29c0;

    mips_top dut0 (
        .i_clock           (clock),
        .i_arst_n          (arst_n),
        .i_pc_enable       (pc_enable),
        .i_im_write_enable (im_we),
        .i_im_address      (im_addr),
        .i_im_data         (im_data),
        .i_rb_address      (rb_addr),
        .i_dm_address      (dm_addr),
        .o_pc_value        (pc_value),
        .o_rb_data         (rb_data),
        .o_dm_data         (dm_data),
        .o_hlt             (hlt)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t sign_extend16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Wraparound arithmetic, signed compare for slt
    function automatic word_t expected_result(input logic [5:0] fn, input word_t a, input word_t b);
        case (fn)
            `FN_ADDU: return a + b;
            `FN_SUBU: return a - b;
            `FN_AND:  return a & b;
            `FN_OR:   return a | b;
            `FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [5:0] pick_op(input int k);
        case (k)
            0:       return `FN_ADDU;
            1:       return `FN_SUBU;
            2:       return `FN_AND;
            3:       return `FN_OR;
            default: return `FN_SLT;
        endcase
    endfunction

    function automatic row_t make_row(input logic [5:0] fn, input logic [15:0] a,
                                      input logic [15:0] b);
        return '{fn: fn, imm_a: a, imm_b: b,
                 expected: expected_result(fn, sign_extend16(a), sign_extend16(b))};
    endfunction

    function automatic word_t encode_rtype(input logic [5:0] fn, input reg_addr_t rs,
                                           input reg_addr_t rt, input reg_addr_t rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_itype(input logic [5:0] op, input reg_addr_t rs,
                                           input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_values(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic fill_rows();
        rows[0] = make_row(`FN_ADDU, 16'h1234, 16'h1234);   // Equal operands
        rows[1] = make_row(`FN_ADDU, 16'hfff0, 16'h8000);   // Both negative
        rows[2] = make_row(`FN_AND,  16'h0000, 16'h0000);
        rows[3] = make_row(`FN_SUBU, 16'h0001, 16'h0002);   // Underflow
        rows[4] = make_row(`FN_SLT,  16'hffff, 16'h0001);
        rows[5] = make_row(`FN_OR,   16'hffff, 16'h0000);   // All ones after extension
        for (int i = 6; i < NUM_ROWS; i++) begin
            rng_state = xorshift32(rng_state);
            rows[i].fn = pick_op(int'(rng_state % 5));
            rng_state = xorshift32(rng_state);
            rows[i] = make_row(rows[i].fn, rng_state[15:0], rng_state[31:16]);
        end
    endtask

    // Two slots between every producer and its consumer
    task automatic build_program(input int idx);
        logic [15:0] offset;
        offset = 16'(4 * idx);
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = '0;
        end
        prog[0]  = encode_itype(`OP_ADDIU, 5'd0, 5'd1, rows[idx].imm_a);
        prog[1]  = encode_itype(`OP_ADDIU, 5'd0, 5'd2, rows[idx].imm_b);
        prog[4]  = encode_rtype(rows[idx].fn, 5'd1, 5'd2, 5'd3);
        prog[7]  = encode_itype(`OP_SW, 5'd0, 5'd3, offset);
        prog[10] = encode_itype(`OP_LW, 5'd0, 5'd4, offset);
        prog[13] = encode_itype(`OP_ADDIU, 5'd4, 5'd0, 16'h0001);  // Target r0
        prog[HALT_IDX] = {`OP_HALT, 26'd0};
    endtask

    task automatic reset_dut();
        @(posedge clock);
        arst_n    <= 1'b0;
        pc_enable <= 1'b0;
        im_we     <= 1'b0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        compare_values({31'd0, hlt}, 32'd0, "o_hlt after reset");
        compare_values(pc_value, 32'd0, "o_pc_value after reset");
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clock);
            im_we   <= 1'b1;
            im_addr <= i[`MIPS_IM_AW-1:0];
            im_data <= prog[i];
        end
        @(posedge clock);
        im_we <= 1'b0;
    endtask

    task automatic read_and_check_reg(input int addr, input word_t exp, input string what);
        @(posedge clock);
        rb_addr <= reg_addr_t'(addr);
        @(negedge clock);
        compare_values(rb_data, exp, what);
        compare_values({31'd0, hlt}, 32'd1, "o_hlt dropped after halt");
    endtask

    task automatic run_row(input int idx);
        word_t pc_hold;
        reset_dut();
        if (idx == SWEEP_ROW) begin
            for (int r = 0; r < `MIPS_NREGS; r++) begin
                @(posedge clock);
                rb_addr <= reg_addr_t'(r);
                @(negedge clock);
                compare_values(rb_data, '0, $sformatf("r%0d after reset", r));
            end
        end
        build_program(idx);
        load_program();
        @(posedge clock);
        pc_enable <= 1'b1;
        if (idx == PAUSE_ROW) begin
            repeat (6) @(posedge clock);
            pc_enable <= 1'b0;
            @(negedge clock);
            pc_hold = pc_value;
            repeat (5) begin
                @(negedge clock);
                compare_values(pc_value, pc_hold, "o_pc_value moved while stopped");
            end
            @(posedge clock);
            pc_enable <= 1'b1;
        end
        while (!hlt) @(negedge clock);     // Watchdog bounds this wait
        compare_values(pc_value, 32'(HALT_IDX * 4 + 4), $sformatf("row %0d halt PC", idx));
        read_and_check_reg(1, sign_extend16(rows[idx].imm_a), $sformatf("row %0d r1", idx));
        read_and_check_reg(2, sign_extend16(rows[idx].imm_b), $sformatf("row %0d r2", idx));
        read_and_check_reg(3, rows[idx].expected, $sformatf("row %0d r3", idx));
        read_and_check_reg(4, rows[idx].expected, $sformatf("row %0d r4 loaded", idx));
        read_and_check_reg(0, '0, $sformatf("row %0d r0", idx));
        @(posedge clock);
        dm_addr <= idx[`MIPS_DM_AW-1:0];
        @(posedge clock);                  // Registered debug read
        @(negedge clock);
        compare_values(dm_data, rows[idx].expected, $sformatf("row %0d stored word", idx));
        compare_values(pc_value, 32'(HALT_IDX * 4 + 4), $sformatf("row %0d PC at rest", idx));
    endtask

    initial begin
        arst_n    = 1'b0;
        pc_enable = 1'b0;
        im_we     = 1'b0;
        im_addr   = '0;
        im_data   = '0;
        rb_addr   = '0;
        dm_addr   = '0;
        fill_rows();
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run timed out before all rows finished");
        abort_run();
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/reg_bank.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_top.sv
sim/tb_mips_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := tb_mips_top
RTL_TOP   := mips_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
